/* run_sim.sh */
#!/bin/sh
# build and run the tank_arena testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_tank_arena; then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_tank_arena > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"
if grep -qF "*** TEST PASSED ***" "$LOG"; then
	exit 0
fi
exit 1

/* sim/tb_arena_model.svh */
`ifndef TB_ARENA_MODEL_SVH
`define TB_ARENA_MODEL_SVH
`default_nettype none

// expected game state, advanced once per tick
int   m_tank_x;
logic m_shot_alive [TANK_SHOTS];
int   m_shot_x [TANK_SHOTS];
int   m_shot_y [TANK_SHOTS];
logic m_mons_alive [MAX_MONSTERS];
logic m_b_alive [MAX_MONSTERS*MONS_SHOTS];
int   m_b_y [MAX_MONSTERS*MONS_SHOTS];
logic m_tank_lost;

function automatic logic near(input int p, input int c, input int half);
	return (p - c <= half) && (c - p <= half);
endfunction

function automatic int mons_col(input int m);
	return int'(MONS_X0) + m * MONS_PITCH;
endfunction

function automatic logic model_cleared();
	logic cleared;
	cleared = 1'b1;
	for (int m = 0; m < MAX_MONSTERS; m++)
		if (m_mons_alive[m])
			cleared = 1'b0;
	return cleared;
endfunction

function automatic logic shots_full();
	return m_shot_alive[0] && m_shot_alive[1] && m_shot_alive[2];
endfunction

function automatic logic shots_any();
	return m_shot_alive[0] || m_shot_alive[1] || m_shot_alive[2];
endfunction

// bullet of monster m that could land while the tank passes its column
// about 32 ticks from the parking spot until the tank is clear again
function automatic logic bullet_nearing_tank(input int m);
	for (int k = 0; k < MONS_SHOTS; k++)
		if (m_b_alive[m*MONS_SHOTS+k] && m_b_y[m*MONS_SHOTS+k] >= int'(TANK_Y) - 40 &&
		    m_b_y[m*MONS_SHOTS+k] <= int'(TANK_Y))
			return 1'b1;
	return 1'b0;
endfunction

task automatic model_reset();
	m_tank_x = TANK_X0;
	m_tank_lost = 1'b0;
	for (int s = 0; s < TANK_SHOTS; s++) begin
		m_shot_alive[s] = 1'b0;
		m_shot_x[s] = 0;
		m_shot_y[s] = 0;
	end
	for (int m = 0; m < MAX_MONSTERS; m++)
		m_mons_alive[m] = (m < NUM_MONSTERS);
	for (int b = 0; b < MAX_MONSTERS * MONS_SHOTS; b++) begin
		m_b_alive[b] = 1'b0;
		m_b_y[b] = 0;
	end
endtask

// one tick with the given fire, left and right inputs
task automatic model_step(input logic f, input logic l, input logic r);
	logic sk [TANK_SHOTS];
	logic mk [MAX_MONSTERS];
	logic go [MAX_MONSTERS*MONS_SHOTS];
	logic hit;
	int   slot;
	int   base;
	hit = 1'b0;
	slot = -1;
	for (int s = 0; s < TANK_SHOTS; s++)
		sk[s] = 1'b0;
	for (int m = 0; m < MAX_MONSTERS; m++)
		mk[m] = 1'b0;
	// collisions seen on the current positions
	for (int s = 0; s < TANK_SHOTS; s++)
		for (int m = 0; m < NUM_MONSTERS; m++)
			if (m_shot_alive[s] && m_mons_alive[m] && m_shot_y[s] == int'(MONS_Y) &&
			    near(m_shot_x[s], mons_col(m), HALF_W)) begin
				sk[s] = 1'b1;
				mk[m] = 1'b1;
			end
	for (int b = 0; b < NUM_MONSTERS * MONS_SHOTS; b++)
		if (m_b_alive[b] && m_b_y[b] == int'(TANK_Y) &&
		    near(mons_col(b / MONS_SHOTS), m_tank_x, HALF_W))
			hit = 1'b1;
	if (f)
		for (int s = TANK_SHOTS - 1; s >= 0; s--)
			if (!m_shot_alive[s])
				slot = s;
	for (int m = 0; m < MAX_MONSTERS; m++) begin
		base = m * MONS_SHOTS;
		for (int k = 0; k < MONS_SHOTS; k++)
			go[base+k] = 1'b0;
		if (m < NUM_MONSTERS && m_mons_alive[m]) begin
			if (!m_b_alive[base])
				go[base] = 1'b1;
			else
				for (int k = 1; k < MONS_SHOTS; k++)
					if (!m_b_alive[base+k] && m_b_y[base] == int'(MONS_Y) + k * SHOT_GAP)
						go[base+k] = 1'b1;
		end
	end
	// shots park on the tank position before it moves
	for (int s = 0; s < TANK_SHOTS; s++) begin
		if (m_shot_alive[s]) begin
			if (sk[s] || m_shot_y[s] == int'(TOP_Y))
				m_shot_alive[s] = 1'b0;
			m_shot_y[s] = m_shot_y[s] - 1;
		end else begin
			m_shot_x[s] = m_tank_x;
			m_shot_y[s] = TANK_Y;
			m_shot_alive[s] = (s == slot);
		end
	end
	if (!f && r)
		m_tank_x = (m_tank_x == int'(WRAP_HI)) ? int'(WRAP_LO) : m_tank_x + TANK_STEP;
	else if (!f && l)
		m_tank_x = (m_tank_x == int'(WRAP_LO)) ? int'(WRAP_HI) : m_tank_x - TANK_STEP;
	for (int b = 0; b < MAX_MONSTERS * MONS_SHOTS; b++) begin
		if (mk[b / MONS_SHOTS]) begin
			m_b_alive[b] = 1'b0;
		end else if (go[b]) begin
			m_b_alive[b] = 1'b1;
			m_b_y[b] = MONS_Y;
		end else if (m_b_alive[b]) begin
			if (m_b_y[b] == int'(FLOOR_Y))
				m_b_alive[b] = 1'b0;
			m_b_y[b] = m_b_y[b] + 1;
		end
	end
	for (int m = 0; m < MAX_MONSTERS; m++)
		if (mk[m])
			m_mons_alive[m] = 1'b0;
	if (hit)
		m_tank_lost = 1'b1;
endtask

// expected colour at one screen position
function automatic rgb_t predict_pixel(input logic b, input int h, input int v);
	logic tank_px;
	logic shot_px;
	logic red_px;
	tank_px = (v >= int'(TANK_Y) - TANK_HEAD_H && v < int'(TANK_Y) &&
	           near(h, m_tank_x, HEAD_HALF_W)) ||
	          (v >= int'(TANK_Y) && v <= int'(TANK_Y) + TANK_BODY_H &&
	           near(h, m_tank_x, HALF_W));
	shot_px = 1'b0;
	red_px = 1'b0;
	for (int s = 0; s < TANK_SHOTS; s++)
		if (m_shot_alive[s] && near(h, m_shot_x[s], SHOT_HALF) && near(v, m_shot_y[s], SHOT_HALF))
			shot_px = 1'b1;
	for (int m = 0; m < NUM_MONSTERS; m++)
		if (m_mons_alive[m] && near(h, mons_col(m), HALF_W) && near(v, MONS_Y, MONS_HALF_H))
			red_px = 1'b1;
	for (int q = 0; q < NUM_MONSTERS * MONS_SHOTS; q++)
		if (m_b_alive[q] && near(h, mons_col(q / MONS_SHOTS), SHOT_HALF) &&
		    near(v, m_b_y[q], SHOT_HALF))
			red_px = 1'b1;
	if (!b)
		return BLACK;
	if (model_cleared())
		return CYAN;
	if (m_tank_lost)
		return RED;
	if (shot_px)
		return BLUE;
	if (tank_px)
		return GREEN;
	if (red_px)
		return RED;
	return BLACK;
endfunction

`default_nettype wire
`endif

/* sim/tb_tank_arena.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tank_arena import arena_pkg::*; ();

	localparam int NUM_MONSTERS = 5;
	// tick count of all tests with headroom, cycles per tick incl. probes
	localparam int TOTAL_TICKS = 3000;
	localparam int TICK_CYCLES = 20;
	localparam int CYCLE_LIMIT = TOTAL_TICKS * TICK_CYCLES * 2 + 2000;

	logic         clk;
	logic         rst;
	logic         tick;
	logic         fire;
	logic         left;
	logic         right;
	logic         bright;
	coord_t       hcount;
	coord_t       vcount;
	rgb_t         rgb;
	game_status_t status;

	int          pixel_errors;
	int          status_errors;
	int          cycles = 0;
	int          mons_probe;
	logic [31:0] rng;

	`include "tb_arena_model.svh"

	tank_arena #(.NUM_MONSTERS(NUM_MONSTERS)) UUT (
		.clk    (clk),
		.rst    (rst),
		.tick   (tick),
		.fire   (fire),
		.left   (left),
		.right  (right),
		.bright (bright),
		.hcount (hcount),
		.vcount (vcount),
		.rgb    (rgb),
		.status (status)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d pixel, %0d status", pixel_errors, status_errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_pixel(input int h, input int v, input logic b);
		rgb_t exp;
		@(negedge clk);
		hcount = coord_t'(h);
		vcount = coord_t'(v);
		bright = b;
		#1;
		exp = predict_pixel(b, h, v);
		assert (rgb === exp) else begin
			pixel_errors++;
			$display("FAIL %0t rgb at (%0d,%0d) expected %h got %h", $time, h, v, exp, rgb);
		end
	endtask

	task automatic check_status();
		game_status_t exp;
		exp.tank_lost = m_tank_lost;
		exp.squad_cleared = model_cleared();
		assert (status === exp) else begin
			status_errors++;
			$display("FAIL %0t status expected %b got %b", $time, exp, status);
		end
	endtask

	task automatic probe_scene();
		check_pixel(m_tank_x + HALF_W, int'(TANK_Y) + 5, 1'b1);
		check_status();
		check_pixel(m_tank_x + HALF_W + 1, int'(TANK_Y) + 5, 1'b1);
		check_pixel(m_tank_x, int'(TANK_Y) - 1, 1'b1);
		check_pixel(m_tank_x, int'(TANK_Y) + 5, 1'b0);
		for (int s = 0; s < TANK_SHOTS; s++)
			if (m_shot_alive[s])
				check_pixel(m_shot_x[s], m_shot_y[s], 1'b1);
		// bullets of the middle monster
		for (int k = 0; k < MONS_SHOTS; k++)
			if (m_b_alive[2*MONS_SHOTS+k])
				check_pixel(mons_col(2), m_b_y[2*MONS_SHOTS+k], 1'b1);
		check_pixel(mons_col(mons_probe), MONS_Y, 1'b1);
		mons_probe = (mons_probe + 1) % NUM_MONSTERS;
		check_pixel(20, 20, 1'b1);
	endtask

	task automatic run_tick(input logic f, input logic l, input logic r);
		int gap;
		int early;
		rng = next_rand(rng);
		gap = int'(rng % 3);
		// fire may arrive as one or two strobes ahead of the tick
		early = f ? int'((rng >> 8) % 3) : 0;
		repeat (early) begin
			@(negedge clk);
			fire = 1'b1;
			@(negedge clk);
			fire = 1'b0;
		end
		@(negedge clk);
		tick = 1'b1;
		fire = f && (early == 0);
		left = l;
		right = r;
		model_step(f, l, r);
		@(negedge clk);
		tick = 1'b0;
		fire = 1'b0;
		left = 1'b0;
		right = 1'b0;
		repeat (gap) @(negedge clk);
		probe_scene();
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		model_reset();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	endtask

	task automatic move_right_to(input int x);
		while (m_tank_x != x)
			run_tick(1'b0, 1'b0, 1'b1);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		tick = 1'b0;
		fire = 1'b0;
		left = 1'b0;
		right = 1'b0;
		bright = 1'b0;
		hcount = '0;
		vcount = '0;
		pixel_errors = 0;
		status_errors = 0;
		mons_probe = 0;
		rng = 32'h366f_7371;

		apply_reset();
		probe_scene();
		for (int m = 0; m < NUM_MONSTERS; m++)
			check_pixel(mons_col(m), MONS_Y, 1'b1);

		// right across the wrap with left also held, then left back over it
		repeat (180) run_tick(1'b0, 1'b1, 1'b1);
		repeat (6) run_tick(1'b0, 1'b1, 1'b0);

		// three shots, a fourth strobe is dropped, right held meanwhile
		repeat (4) run_tick(1'b1, 1'b0, 1'b1);
		while (shots_any())
			run_tick(1'b0, 1'b0, 1'b0);

		// park between columns until no bullet is about to land,
		// then step under monster m and fire
		for (int m = 0; m < NUM_MONSTERS; m++) begin
			move_right_to(mons_col(m) - 50);
			while (shots_full() || bullet_nearing_tank(m))
				run_tick(1'b0, 1'b0, 1'b0);
			move_right_to(mons_col(m));
			run_tick(1'b1, 1'b0, 1'b0);
		end
		move_right_to(mons_col(NUM_MONSTERS - 1) + 50);
		while (!model_cleared())
			run_tick(1'b0, 1'b0, 1'b0);
		repeat (3) run_tick(1'b0, 1'b0, 1'b0);
		check_pixel(mons_col(2), MONS_Y, 1'b1);
		check_pixel(600, 300, 1'b1);

		// tank stays under the middle monster until hit
		apply_reset();
		while (!m_tank_lost)
			run_tick(1'b0, 1'b0, 1'b0);
		repeat (3) run_tick(1'b0, 1'b0, 1'b0);
		check_pixel(100, 400, 1'b1);
		check_status();

		$display("errors: %0d pixel, %0d status", pixel_errors, status_errors);
		if (pixel_errors == 0 && status_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/arena_pkg.sv */
`default_nettype none

package arena_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [11:0] rgb_t;

	localparam int TANK_SHOTS   = 3;
	localparam int MONS_SHOTS   = 3;
	localparam int MAX_MONSTERS = 5;

	// playfield geometry, screen pixels
	localparam coord_t TANK_X0    = 10'd450;
	localparam coord_t TANK_Y     = 10'd450;
	localparam coord_t WRAP_LO    = 10'd150;
	localparam coord_t WRAP_HI    = 10'd800;
	localparam coord_t MONS_X0    = 10'd250;
	localparam coord_t MONS_Y     = 10'd100;
	localparam coord_t TOP_Y      = 10'd32;
	localparam coord_t FLOOR_Y    = 10'd514;
	localparam int     TANK_STEP  = 2;
	localparam int     MONS_PITCH = 100;
	localparam int     SHOT_GAP   = 200;

	// shape sizes
	localparam int HALF_W      = 10;
	localparam int MONS_HALF_H = 5;
	localparam int TANK_HEAD_H = 5;
	localparam int TANK_BODY_H = 10;
	localparam int HEAD_HALF_W = 2;
	localparam int SHOT_HALF   = 1;

	localparam rgb_t BLACK = 12'h000;
	localparam rgb_t RED   = 12'hF00;
	localparam rgb_t GREEN = 12'h0F0;
	localparam rgb_t BLUE  = 12'h00F;
	localparam rgb_t CYAN  = 12'h0FF;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} obj_pos_t;

	typedef struct packed {
		logic     alive;
		obj_pos_t pos;
	} shot_t;

	typedef struct packed {
		obj_pos_t                 pos;
		shot_t [TANK_SHOTS-1:0]   shots;
	} tank_view_t;

	// bullets of monster m sit at m*MONS_SHOTS .. m*MONS_SHOTS+MONS_SHOTS-1
	typedef struct packed {
		logic [MAX_MONSTERS-1:0]             alive;
		shot_t [MAX_MONSTERS*MONS_SHOTS-1:0] shots;
	} squad_view_t;

	typedef enum logic [1:0] {
		CMD_HOLD,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_FIRE
	} move_cmd_t;

	typedef struct packed {
		logic tank_lost;
		logic squad_cleared;
	} game_status_t;

	function automatic coord_t mons_x(input int idx);
		return coord_t'(int'(MONS_X0) + idx * MONS_PITCH);
	endfunction

	// true when p lies within half pixels of c
	function automatic logic in_span(input coord_t p, input coord_t c, input int half);
		return (int'(p) + half >= int'(c)) && (int'(p) <= int'(c) + half);
	endfunction

endpackage

`default_nettype wire

/* verilog/combat_judge.sv */
`timescale 1ns/1ps
`default_nettype none

module combat_judge import arena_pkg::*; #(
	parameter int NUM_MONSTERS = 5
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    tick,
	input  tank_view_t              tank_view,
	input  squad_view_t             squad_view,
	output logic [TANK_SHOTS-1:0]   shot_kill,
	output logic [MAX_MONSTERS-1:0] monster_kill,
	output game_status_t            status
);

	logic tank_hit;
	logic tank_lost;

	always_comb begin
		shot_kill = '0;
		monster_kill = '0;
		tank_hit = 1'b0;
		// tank shots against the monster row
		for (int s = 0; s < TANK_SHOTS; s++) begin
			for (int m = 0; m < NUM_MONSTERS; m++) begin
				if (tank_view.shots[s].alive && squad_view.alive[m] &&
				    tank_view.shots[s].pos.y == MONS_Y &&
				    in_span(tank_view.shots[s].pos.x, mons_x(m), HALF_W)) begin
					shot_kill[s] = 1'b1;
					monster_kill[m] = 1'b1;
				end
			end
		end
		// monster bullets against the tank row
		for (int b = 0; b < NUM_MONSTERS * MONS_SHOTS; b++) begin
			if (squad_view.shots[b].alive && squad_view.shots[b].pos.y == TANK_Y &&
			    in_span(squad_view.shots[b].pos.x, tank_view.pos.x, HALF_W))
				tank_hit = 1'b1;
		end
	end

	// sticky until reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			tank_lost <= 1'b0;
		else if (tick && tank_hit)
			tank_lost <= 1'b1;
	end

	assign status.tank_lost = tank_lost;
	assign status.squad_cleared = ~|squad_view.alive;

endmodule

`default_nettype wire

/* verilog/monster_squad.sv */
`timescale 1ns/1ps
`default_nettype none

module monster_squad import arena_pkg::*; #(
	parameter int NUM_MONSTERS = 5
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    tick,
	input  logic [MAX_MONSTERS-1:0] monster_kill,
	output squad_view_t             squad_view
);

	localparam int NUM_SLOTS = MAX_MONSTERS * MONS_SHOTS;

	logic [MAX_MONSTERS-1:0] mons_alive;
	logic [NUM_SLOTS-1:0]    b_alive;
	logic [NUM_SLOTS-1:0]    launch;
	coord_t                  b_y [NUM_SLOTS];

	// slot 0 fires whenever free, later slots wait for slot 0
	// to reach their stagger row
	always_comb begin
		launch = '0;
		for (int m = 0; m < NUM_MONSTERS; m++) begin
			if (mons_alive[m]) begin
				if (!b_alive[m*MONS_SHOTS]) begin
					launch[m*MONS_SHOTS] = 1'b1;
				end else begin
					for (int k = 1; k < MONS_SHOTS; k++) begin
						if (!b_alive[m*MONS_SHOTS+k] &&
						    b_y[m*MONS_SHOTS] == coord_t'(int'(MONS_Y) + k * SHOT_GAP))
							launch[m*MONS_SHOTS+k] = 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int m = 0; m < MAX_MONSTERS; m++)
				mons_alive[m] <= (m < NUM_MONSTERS);
			b_alive <= '0;
		end else if (tick) begin
			for (int m = 0; m < MAX_MONSTERS; m++) begin
				// a kill takes the monster and everything it dropped
				if (monster_kill[m])
					mons_alive[m] <= 1'b0;
				for (int k = 0; k < MONS_SHOTS; k++) begin
					if (monster_kill[m])
						b_alive[m*MONS_SHOTS+k] <= 1'b0;
					else if (launch[m*MONS_SHOTS+k])
						b_alive[m*MONS_SHOTS+k] <= 1'b1;
					else if (b_alive[m*MONS_SHOTS+k] && b_y[m*MONS_SHOTS+k] == FLOOR_Y)
						b_alive[m*MONS_SHOTS+k] <= 1'b0;
				end
			end
		end
	end

	// bullet rows; parked at the monster row while dead
	always_ff @(posedge clk) begin
		if (tick) begin
			for (int b = 0; b < NUM_SLOTS; b++) begin
				if (b_alive[b] && !launch[b])
					b_y[b] <= b_y[b] + 1'b1;
				else
					b_y[b] <= MONS_Y;
			end
		end
	end

	always_comb begin
		squad_view.alive = mons_alive;
		for (int m = 0; m < MAX_MONSTERS; m++) begin
			for (int k = 0; k < MONS_SHOTS; k++) begin
				squad_view.shots[m*MONS_SHOTS+k].alive = b_alive[m*MONS_SHOTS+k];
				squad_view.shots[m*MONS_SHOTS+k].pos.x = mons_x(m);
				squad_view.shots[m*MONS_SHOTS+k].pos.y = b_y[m*MONS_SHOTS+k];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/pixel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer import arena_pkg::*; #(
	parameter int NUM_MONSTERS = 5
) (
	input  logic         bright,
	input  coord_t       hcount,
	input  coord_t       vcount,
	input  tank_view_t   tank_view,
	input  squad_view_t  squad_view,
	input  game_status_t status,
	output rgb_t         rgb
);

	logic head_px;
	logic body_px;
	logic shot_px;
	logic mons_px;
	logic bullet_px;

	// head is a narrow stub just above the body
	assign head_px = int'(vcount) >= int'(TANK_Y) - TANK_HEAD_H && vcount < TANK_Y &&
	                 in_span(hcount, tank_view.pos.x, HEAD_HALF_W);
	assign body_px = vcount >= TANK_Y && int'(vcount) <= int'(TANK_Y) + TANK_BODY_H &&
	                 in_span(hcount, tank_view.pos.x, HALF_W);

	always_comb begin
		shot_px = 1'b0;
		mons_px = 1'b0;
		bullet_px = 1'b0;
		for (int s = 0; s < TANK_SHOTS; s++) begin
			if (tank_view.shots[s].alive &&
			    in_span(vcount, tank_view.shots[s].pos.y, SHOT_HALF) &&
			    in_span(hcount, tank_view.shots[s].pos.x, SHOT_HALF))
				shot_px = 1'b1;
		end
		for (int m = 0; m < NUM_MONSTERS; m++) begin
			if (squad_view.alive[m] && in_span(vcount, MONS_Y, MONS_HALF_H) &&
			    in_span(hcount, mons_x(m), HALF_W))
				mons_px = 1'b1;
		end
		for (int b = 0; b < NUM_MONSTERS * MONS_SHOTS; b++) begin
			if (squad_view.shots[b].alive &&
			    in_span(vcount, squad_view.shots[b].pos.y, SHOT_HALF) &&
			    in_span(hcount, squad_view.shots[b].pos.x, SHOT_HALF))
				bullet_px = 1'b1;
		end
	end

	// end-of-game screens take over the whole visible area
	always_comb begin
		if (!bright)
			rgb = BLACK;
		else if (status.squad_cleared)
			rgb = CYAN;
		else if (status.tank_lost)
			rgb = RED;
		else if (shot_px)
			rgb = BLUE;
		else if (head_px || body_px)
			rgb = GREEN;
		else if (mons_px || bullet_px)
			rgb = RED;
		else
			rgb = BLACK;
	end

endmodule

`default_nettype wire

/* verilog/tank_arena.sv */
`timescale 1ns/1ps
`default_nettype none

module tank_arena import arena_pkg::*; #(
	parameter int NUM_MONSTERS = 5
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         tick,
	input  logic         fire,
	input  logic         left,
	input  logic         right,
	input  logic         bright,
	input  coord_t       hcount,
	input  coord_t       vcount,
	output rgb_t         rgb,
	output game_status_t status
);

	tank_view_t              tank_view;
	squad_view_t             squad_view;
	logic [TANK_SHOTS-1:0]   shot_kill;
	logic [MAX_MONSTERS-1:0] monster_kill;

	tank_unit u_tank (
		.clk       (clk),
		.rst       (rst),
		.tick      (tick),
		.fire      (fire),
		.left      (left),
		.right     (right),
		.shot_kill (shot_kill),
		.tank_view (tank_view)
	);

	monster_squad #(.NUM_MONSTERS(NUM_MONSTERS)) u_squad (
		.clk          (clk),
		.rst          (rst),
		.tick         (tick),
		.monster_kill (monster_kill),
		.squad_view   (squad_view)
	);

	// kill flags loop back to both sides for the next tick
	combat_judge #(.NUM_MONSTERS(NUM_MONSTERS)) u_judge (
		.clk          (clk),
		.rst          (rst),
		.tick         (tick),
		.tank_view    (tank_view),
		.squad_view   (squad_view),
		.shot_kill    (shot_kill),
		.monster_kill (monster_kill),
		.status       (status)
	);

	pixel_mixer #(.NUM_MONSTERS(NUM_MONSTERS)) u_mixer (
		.bright     (bright),
		.hcount     (hcount),
		.vcount     (vcount),
		.tank_view  (tank_view),
		.squad_view (squad_view),
		.status     (status),
		.rgb        (rgb)
	);

endmodule

`default_nettype wire

/* verilog/tank_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tank_unit import arena_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tick,
	input  logic                  fire,
	input  logic                  left,
	input  logic                  right,
	input  logic [TANK_SHOTS-1:0] shot_kill,
	output tank_view_t            tank_view
);

	logic                  fire_req;
	logic                  fire_pend;
	move_cmd_t             cmd;
	coord_t                tank_x;
	logic [TANK_SHOTS-1:0] shot_alive;
	logic [TANK_SHOTS-1:0] launch;
	obj_pos_t              shot_pos [TANK_SHOTS];

	// fire strobes between ticks collapse into one request
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fire_req <= 1'b0;
		end else if (tick) begin
			fire_req <= 1'b0;
		end else if (fire) begin
			fire_req <= 1'b1;
		end
	end

	assign fire_pend = fire_req | fire;

	// fire wins over right, right over left
	always_comb begin
		if (fire_pend)
			cmd = CMD_FIRE;
		else if (right)
			cmd = CMD_RIGHT;
		else if (left)
			cmd = CMD_LEFT;
		else
			cmd = CMD_HOLD;
	end

	// pick the lowest dead shot
	always_comb begin
		launch = '0;
		if (cmd == CMD_FIRE) begin
			for (int s = TANK_SHOTS - 1; s >= 0; s--) begin
				if (!shot_alive[s]) begin
					launch = '0;
					launch[s] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tank_x <= TANK_X0;
			shot_alive <= '0;
		end else if (tick) begin
			case (cmd)
				CMD_RIGHT: tank_x <= (tank_x == WRAP_HI) ? WRAP_LO : tank_x + coord_t'(TANK_STEP);
				CMD_LEFT:  tank_x <= (tank_x == WRAP_LO) ? WRAP_HI : tank_x - coord_t'(TANK_STEP);
				default:   tank_x <= tank_x;
			endcase
			for (int s = 0; s < TANK_SHOTS; s++) begin
				if (shot_alive[s] && (shot_kill[s] || shot_pos[s].y == TOP_Y))
					shot_alive[s] <= 1'b0;
				else if (launch[s])
					shot_alive[s] <= 1'b1;
			end
		end
	end

	// live shots climb, dead ones sit on the tank ready to launch
	always_ff @(posedge clk) begin
		if (tick) begin
			for (int s = 0; s < TANK_SHOTS; s++) begin
				if (shot_alive[s]) begin
					shot_pos[s].y <= shot_pos[s].y - 1'b1;
				end else begin
					shot_pos[s].x <= tank_x;
					shot_pos[s].y <= TANK_Y;
				end
			end
		end
	end

	always_comb begin
		tank_view.pos.x = tank_x;
		tank_view.pos.y = TANK_Y;
		for (int s = 0; s < TANK_SHOTS; s++) begin
			tank_view.shots[s].alive = shot_alive[s];
			tank_view.shots[s].pos = shot_pos[s];
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+sim
verilog/arena_pkg.sv
verilog/tank_unit.sv
verilog/monster_squad.sv
verilog/combat_judge.sv
verilog/pixel_mixer.sv
verilog/tank_arena.sv
sim/tb_tank_arena.sv
